// File: src.f
isa_pkg.sv
core_pkg.sv
issue_queue.sv
scoreboard.sv
reg_file.sv
exec_lane.sv
wb_arbiter.sv
issue_core.sv
tb_clock.sv
tb_issue_core.sv

// File: tb_issue_core.sv
`timescale 1ns/1ps

module tb_issue_core;
    import isa_pkg::*;
    import core_pkg::*;

    localparam int ACCEPT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 400;
    localparam int RESET_TIMEOUT  = 20;
    localparam int PHASE_PAIRS    = 60;

    logic                  clk;
    logic                  reset;
    logic                  in_valid_a;
    logic                  in_valid_b;
    op_t                   in_op_a;
    op_t                   in_op_b;
    logic [REG_ADDR_W-1:0] in_dest_a;
    logic [REG_ADDR_W-1:0] in_dest_b;
    logic [REG_ADDR_W-1:0] in_srca_a;
    logic [REG_ADDR_W-1:0] in_srca_b;
    logic [REG_ADDR_W-1:0] in_srcb_a;
    logic [REG_ADDR_W-1:0] in_srcb_b;
    logic [IMM_W-1:0]      in_imm_a;
    logic [IMM_W-1:0]      in_imm_b;
    logic                  in_ready;
    logic                  issue_a;
    logic                  issue_b;
    logic                  commit_valid;
    logic [REG_ADDR_W-1:0] commit_dest;
    logic [WORD_W-1:0]     commit_data;

    integer seed;
    int     err_cnt;
    int     acc_cnt;
    int     iss_cnt;
    int     commit_cnt;
    int     pair_cnt;
    int     tests_run;
    int     tests_failed;
    logic   saw_full;

    // reference model state, plus program order for the pairing check
    logic [WORD_W-1:0]     model_regs [NUM_REGS];
    logic [WORD_W-1:0]     exp_q [NUM_REGS][$];
    op_t                   pg_op [$];
    logic [REG_ADDR_W-1:0] pg_dest [$];
    logic [REG_ADDR_W-1:0] pg_srca [$];
    logic [REG_ADDR_W-1:0] pg_srcb [$];

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    issue_core DUT (
        .clk          (clk),
        .reset        (reset),
        .in_valid_a   (in_valid_a),
        .in_valid_b   (in_valid_b),
        .in_op_a      (in_op_a),
        .in_op_b      (in_op_b),
        .in_dest_a    (in_dest_a),
        .in_dest_b    (in_dest_b),
        .in_srca_a    (in_srca_a),
        .in_srca_b    (in_srca_b),
        .in_srcb_a    (in_srcb_a),
        .in_srcb_b    (in_srcb_b),
        .in_imm_a     (in_imm_a),
        .in_imm_b     (in_imm_b),
        .in_ready     (in_ready),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .commit_valid (commit_valid),
        .commit_dest  (commit_dest),
        .commit_data  (commit_data)
    );

    function automatic logic [WORD_W-1:0] expected_result(input op_t op,
                                                          input logic [WORD_W-1:0] a,
                                                          input logic [WORD_W-1:0] b,
                                                          input logic [IMM_W-1:0] imm);
        logic [WORD_W-1:0] imm_word;
        imm_word = WORD_W'($signed(imm));
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ADDI:    return a + imm_word;
            default: return '0;
        endcase
    endfunction

    function automatic int pending_count();
        int total;
        total = 0;
        for (int r = 0; r < NUM_REGS; r++)
            total += exp_q[r].size();
        return total;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic run_model(input op_t op, input logic [REG_ADDR_W-1:0] dest,
                             input logic [REG_ADDR_W-1:0] srca,
                             input logic [REG_ADDR_W-1:0] srcb,
                             input logic [IMM_W-1:0] imm);
        logic [WORD_W-1:0] result;
        result = expected_result(op, model_regs[srca], model_regs[srcb], imm);
        model_regs[dest] = result;
        exp_q[dest].push_back(result);
        pg_op.push_back(op);
        pg_dest.push_back(dest);
        pg_srca.push_back(srca);
        pg_srcb.push_back(srcb);
    endtask

    // i is the program index of slot A
    task automatic check_pair(input int i);
        logic rule_ok;
        rule_ok = 1'b0;
        if (pg_dest.size() > i + 1)
            rule_ok = (pg_srca[i+1] != pg_dest[i])
                   && (pg_op[i+1] == ADDI || pg_srcb[i+1] != pg_dest[i])
                   && (pg_dest[i+1] != pg_dest[i]);
        assert (rule_ok)
        else
        begin
            $display("** Error at %0t: paired issue at index %0d breaks the pairing rule",
                     $time, i);
            err_cnt++;
        end
    endtask

    // everything is stable at the falling edge, one half period after the inputs move
    always @(negedge clk)
    begin
        if (reset)
        begin
            if (commit_valid)
            begin
                assert (exp_q[commit_dest].size() > 0)
                else
                begin
                    $display("commit to r%0d arrived with no instruction outstanding",
                             commit_dest);
                    err_cnt++;
                end
                if (exp_q[commit_dest].size() > 0)
                begin
                    assert (commit_data == exp_q[commit_dest][0])
                    else
                    begin
                        $display("** Error at %0t: r%0d committed %h, expected %h", $time,
                                 commit_dest, commit_data, exp_q[commit_dest][0]);
                        err_cnt++;
                    end
                    void'(exp_q[commit_dest].pop_front());
                end
                commit_cnt++;
            end
            assert (!issue_b || issue_a)
            else
            begin
                $display("** Error at %0t: issue_b high without issue_a", $time);
                err_cnt++;
            end
            if (issue_a && issue_b)
                check_pair(iss_cnt);
            assert (in_ready == ((acc_cnt - iss_cnt) <= QUEUE_DEPTH - 2))
            else
            begin
                $display("** Error at %0t: in_ready %0b with %0d entries queued", $time,
                         in_ready, acc_cnt - iss_cnt);
                err_cnt++;
            end
            if (!in_ready)
                saw_full = 1'b1;
            if (issue_b)
                pair_cnt++;
            iss_cnt += int'(issue_a) + int'(issue_b);
            if (in_valid_a && in_ready)
            begin
                run_model(in_op_a, in_dest_a, in_srca_a, in_srcb_a, in_imm_a);
                acc_cnt++;
                if (in_valid_b)
                begin
                    run_model(in_op_b, in_dest_b, in_srca_b, in_srcb_b, in_imm_b);
                    acc_cnt++;
                end
            end
        end
    end

    task automatic pick_instr(input int lo, input int span, output op_t op,
                              output logic [REG_ADDR_W-1:0] dest,
                              output logic [REG_ADDR_W-1:0] srca,
                              output logic [REG_ADDR_W-1:0] srcb,
                              output logic [IMM_W-1:0] imm);
        int r;
        r    = $random(seed);
        op   = op_t'($unsigned(r) % 7);
        dest = REG_ADDR_W'(lo + $unsigned($random(seed)) % span);
        srca = REG_ADDR_W'(lo + $unsigned($random(seed)) % span);
        srcb = REG_ADDR_W'(lo + $unsigned($random(seed)) % span);
        imm  = IMM_W'($random(seed));
    endtask

    // inputs hold until the pair is taken, then valid drops
    task automatic wait_accept();
        int   cycles;
        logic taken;
        cycles = 0;
        taken  = 1'b0;
        while (!taken)
        begin
            @(negedge clk);
            taken = in_ready;
            cycles++;
            if (!taken && cycles > ACCEPT_TIMEOUT)
                abort_run("timeout: decode pair was never accepted");
        end
        @(posedge clk);
        #1;
        in_valid_a = 1'b0;
        in_valid_b = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        do
        begin
            @(posedge clk);
            cycles++;
            if (cycles > DRAIN_TIMEOUT)
                abort_run("timeout: accepted instructions did not all commit");
        end
        while (commit_cnt < acc_cnt);
        #1;
    endtask

    // disjoint puts slot B on r4..r7 and slot A on r0..r3
    task automatic run_phase(input logic disjoint);
        for (int n = 0; n < PHASE_PAIRS; n++)
        begin
            pick_instr(0, 4, in_op_a, in_dest_a, in_srca_a, in_srcb_a, in_imm_a);
            pick_instr(disjoint ? 4 : 0, 4, in_op_b, in_dest_b, in_srca_b, in_srcb_b,
                       in_imm_b);
            in_valid_b = ($random(seed) % 4) != 0;
            in_valid_a = 1'b1;
            wait_accept();
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (err_cnt == errs_before)
            $display("test %s: pass", name);
        else
        begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    initial
    begin
        int cycles;
        int errs_before;
        int pairs_before;
        seed         = 43650;
        err_cnt      = 0;
        acc_cnt      = 0;
        iss_cnt      = 0;
        commit_cnt   = 0;
        pair_cnt     = 0;
        tests_run    = 0;
        tests_failed = 0;
        saw_full     = 1'b0;
        in_valid_a   = 1'b0;
        in_valid_b   = 1'b0;
        in_op_a      = ADD;
        in_op_b      = ADD;
        in_dest_a    = '0;
        in_dest_b    = '0;
        in_srca_a    = '0;
        in_srca_b    = '0;
        in_srcb_a    = '0;
        in_srcb_b    = '0;
        in_imm_a     = '0;
        in_imm_b     = '0;
        for (int r = 0; r < NUM_REGS; r++)
            model_regs[r] = '0;

        cycles = 0;
        while (!reset)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > RESET_TIMEOUT)
                abort_run("timeout: reset was never released");
        end
        errs_before = err_cnt;
        assert (!commit_valid && !issue_a && !issue_b && in_ready)
        else
        begin
            $display("** Error at %0t: outputs not idle after reset", $time);
            err_cnt++;
        end
        finish_test("reset_state", errs_before);
        @(posedge clk);
        #1;

        errs_before = err_cnt;
        for (int k = 0; k < NUM_REGS; k += 2)
        begin
            in_op_a    = ADDI;
            in_op_b    = ADDI;
            in_dest_a  = REG_ADDR_W'(k);
            in_dest_b  = REG_ADDR_W'(k + 1);
            in_srca_a  = REG_ADDR_W'(k);
            in_srca_b  = REG_ADDR_W'(k + 1);
            in_srcb_a  = REG_ADDR_W'(k);
            in_srcb_b  = REG_ADDR_W'(k + 1);
            in_imm_a   = IMM_W'($random(seed));
            in_imm_b   = IMM_W'($random(seed));
            in_valid_a = 1'b1;
            in_valid_b = 1'b1;
            wait_accept();
        end
        wait_drain();
        finish_test("register_init", errs_before);

        errs_before = err_cnt;
        saw_full    = 1'b0;
        run_phase(1'b0);
        wait_drain();
        assert (saw_full)
        else
        begin
            $display("in_ready never fell while dependent chains were queued");
            err_cnt++;
        end
        finish_test("dependent_chains", errs_before);

        errs_before  = err_cnt;
        pairs_before = pair_cnt;
        run_phase(1'b1);
        wait_drain();
        assert (pair_cnt > pairs_before)
        else
        begin
            $display("no paired issue seen with disjoint registers");
            err_cnt++;
        end
        finish_test("disjoint_pairs", errs_before);

        errs_before = err_cnt;
        assert (iss_cnt == acc_cnt && commit_cnt == acc_cnt)
        else
        begin
            $display("** Error at %0t: accepted %0d, issued %0d, committed %0d", $time,
                     acc_cnt, iss_cnt, commit_cnt);
            err_cnt++;
        end
        assert (pending_count() == 0)
        else
        begin
            $display("** Error at %0t: %0d results never committed", $time, pending_count());
            err_cnt++;
        end
        finish_test("drain_totals", errs_before);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 err_cnt);
        if (err_cnt == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);
    // reset stays low through the first three rising edges
    initial
    begin
        clk   = 1'b0;
        reset = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b1;
    end

    always #50 clk = ~clk;

endmodule

// File: issue_core.sv
`timescale 1ns/1ps

module issue_core (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           in_valid_a,
    input  logic                           in_valid_b,
    input  isa_pkg::op_t                   in_op_a,
    input  isa_pkg::op_t                   in_op_b,
    input  logic [isa_pkg::REG_ADDR_W-1:0] in_dest_a,
    input  logic [isa_pkg::REG_ADDR_W-1:0] in_dest_b,
    input  logic [isa_pkg::REG_ADDR_W-1:0] in_srca_a,
    input  logic [isa_pkg::REG_ADDR_W-1:0] in_srca_b,
    input  logic [isa_pkg::REG_ADDR_W-1:0] in_srcb_a,
    input  logic [isa_pkg::REG_ADDR_W-1:0] in_srcb_b,
    input  logic [isa_pkg::IMM_W-1:0]      in_imm_a,
    input  logic [isa_pkg::IMM_W-1:0]      in_imm_b,
    output logic                           in_ready,
    output logic                           issue_a,
    output logic                           issue_b,
    output logic                           commit_valid,
    output logic [isa_pkg::REG_ADDR_W-1:0] commit_dest,
    output logic [isa_pkg::WORD_W-1:0]     commit_data
);
    import isa_pkg::*;
    import core_pkg::*;

    logic [3:0][REG_ADDR_W-1:0]         rd_addr;
    logic [3:0][WORD_W-1:0]             rd_data;
    logic [3:0]                         src_busy;
    logic [1:0]                         dest_busy;
    logic [NUM_LANES-1:0]               lane_ready;
    op_t                                iss_op_a;
    op_t                                iss_op_b;
    logic [REG_ADDR_W-1:0]              iss_dest_a;
    logic [REG_ADDR_W-1:0]              iss_dest_b;
    logic [IMM_W-1:0]                   iss_imm_a;
    logic [IMM_W-1:0]                   iss_imm_b;
    logic [NUM_LANES-1:0]               res_valid;
    logic [NUM_LANES-1:0]               res_ready;
    logic [NUM_LANES-1:0][REG_ADDR_W-1:0] res_dest;
    logic [NUM_LANES-1:0][WORD_W-1:0]     res_data;

    issue_queue u_queue (
        .clk        (clk),
        .reset      (reset),
        .in_valid_a (in_valid_a),
        .in_valid_b (in_valid_b),
        .in_op_a    (in_op_a),
        .in_op_b    (in_op_b),
        .in_dest_a  (in_dest_a),
        .in_dest_b  (in_dest_b),
        .in_srca_a  (in_srca_a),
        .in_srca_b  (in_srca_b),
        .in_srcb_a  (in_srcb_a),
        .in_srcb_b  (in_srcb_b),
        .in_imm_a   (in_imm_a),
        .in_imm_b   (in_imm_b),
        .in_ready   (in_ready),
        .rd_addr    (rd_addr),
        .src_busy   (src_busy),
        .dest_busy  (dest_busy),
        .lane_ready (lane_ready),
        .issue_a    (issue_a),
        .issue_b    (issue_b),
        .iss_op_a   (iss_op_a),
        .iss_op_b   (iss_op_b),
        .iss_dest_a (iss_dest_a),
        .iss_dest_b (iss_dest_b),
        .iss_imm_a  (iss_imm_a),
        .iss_imm_b  (iss_imm_b)
    );

    scoreboard u_scoreboard (
        .clk        (clk),
        .reset      (reset),
        .query_addr (rd_addr),
        .query_dest ({iss_dest_b, iss_dest_a}),
        .query_busy (src_busy),
        .dest_busy  (dest_busy),
        .set_a      (issue_a),
        .set_b      (issue_b),
        .set_dest_a (iss_dest_a),
        .set_dest_b (iss_dest_b),
        .clear      (commit_valid),
        .clear_dest (commit_dest)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr_en   (commit_valid),
        .wr_addr (commit_dest),
        .wr_data (commit_data)
    );

    // slot A operands sit on read ports 0 and 1, slot B on 2 and 3
    exec_lane lane0 (
        .clk        (clk),
        .reset      (reset),
        .issue      (issue_a),
        .op         (iss_op_a),
        .opnd_a     (rd_data[0]),
        .opnd_b     (rd_data[1]),
        .imm        (iss_imm_a),
        .dest       (iss_dest_a),
        .lane_ready (lane_ready[0]),
        .res_valid  (res_valid[0]),
        .res_ready  (res_ready[0]),
        .res_dest   (res_dest[0]),
        .res_data   (res_data[0])
    );

    exec_lane lane1 (
        .clk        (clk),
        .reset      (reset),
        .issue      (issue_b),
        .op         (iss_op_b),
        .opnd_a     (rd_data[2]),
        .opnd_b     (rd_data[3]),
        .imm        (iss_imm_b),
        .dest       (iss_dest_b),
        .lane_ready (lane_ready[1]),
        .res_valid  (res_valid[1]),
        .res_ready  (res_ready[1]),
        .res_dest   (res_dest[1]),
        .res_data   (res_data[1])
    );

    wb_arbiter u_arbiter (
        .clk          (clk),
        .reset        (reset),
        .res_valid    (res_valid),
        .res_dest     (res_dest),
        .res_data     (res_data),
        .res_ready    (res_ready),
        .commit_valid (commit_valid),
        .commit_dest  (commit_dest),
        .commit_data  (commit_data)
    );

endmodule

// File: wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter (
    input  logic                                                   clk,
    input  logic                                                   reset,
    input  logic [core_pkg::NUM_LANES-1:0]                         res_valid,
    input  logic [core_pkg::NUM_LANES-1:0][isa_pkg::REG_ADDR_W-1:0] res_dest,
    input  logic [core_pkg::NUM_LANES-1:0][isa_pkg::WORD_W-1:0]     res_data,
    output logic [core_pkg::NUM_LANES-1:0]                         res_ready,
    output logic                                                   commit_valid,
    output logic [isa_pkg::REG_ADDR_W-1:0]                         commit_dest,
    output logic [isa_pkg::WORD_W-1:0]                             commit_data
);
    import core_pkg::*;

    logic                 rr_ptr;
    logic [NUM_LANES-1:0] grant;

    // pointer lane wins when both lanes ask
    assign grant[0] = res_valid[0] && (!res_valid[1] || !rr_ptr);
    assign grant[1] = res_valid[1] && (!res_valid[0] || rr_ptr);
    assign res_ready = grant;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            rr_ptr       <= 1'b0;
            commit_valid <= 1'b0;
        end
        else
        begin
            commit_valid <= |grant;
            if (grant[0])
                rr_ptr <= 1'b1;
            else if (grant[1])
                rr_ptr <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (grant[1])
        begin
            commit_dest <= res_dest[1];
            commit_data <= res_data[1];
        end
        else
        begin
            commit_dest <= res_dest[0];
            commit_data <= res_data[0];
        end
    end

endmodule

// File: exec_lane.sv
`timescale 1ns/1ps

module exec_lane (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           issue,
    input  isa_pkg::op_t                   op,
    input  logic [isa_pkg::WORD_W-1:0]     opnd_a,
    input  logic [isa_pkg::WORD_W-1:0]     opnd_b,
    input  logic [isa_pkg::IMM_W-1:0]      imm,
    input  logic [isa_pkg::REG_ADDR_W-1:0] dest,
    output logic                           lane_ready,
    output logic                           res_valid,
    input  logic                           res_ready,
    output logic [isa_pkg::REG_ADDR_W-1:0] res_dest,
    output logic [isa_pkg::WORD_W-1:0]     res_data
);
    import isa_pkg::*;

    logic                  full;
    op_t                   op_q;
    logic [WORD_W-1:0]     a_q;
    logic [WORD_W-1:0]     b_q;
    logic [IMM_W-1:0]      imm_q;
    logic [REG_ADDR_W-1:0] dest_q;
    logic [WORD_W-1:0]     imm_ext;

    // a result granted this cycle frees the slot for a new issue
    assign lane_ready = !full || res_ready;
    assign res_valid  = full;
    assign res_dest   = dest_q;
    assign imm_ext    = {{(WORD_W - IMM_W){imm_q[IMM_W-1]}}, imm_q};

    always_ff @(posedge clk)
    begin
        if (!reset)
            full <= 1'b0;
        else if (issue)
            full <= 1'b1;
        else if (res_ready)
            full <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            op_q   <= op;
            a_q    <= opnd_a;
            b_q    <= opnd_b;
            imm_q  <= imm;
            dest_q <= dest;
        end
    end

    always_comb
    begin
        case (op_q)
            ADD:     res_data = a_q + b_q;
            SUB:     res_data = a_q - b_q;
            AND:     res_data = a_q & b_q;
            OR:      res_data = a_q | b_q;
            XOR:     res_data = a_q ^ b_q;
            SLT:     res_data = {{(WORD_W - 1){1'b0}}, $signed(a_q) < $signed(b_q)};
            ADDI:    res_data = a_q + imm_ext;
            default: res_data = '0;
        endcase
    end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [3:0][isa_pkg::REG_ADDR_W-1:0] rd_addr,
    output logic [3:0][isa_pkg::WORD_W-1:0]     rd_data,
    input  logic                                wr_en,
    input  logic [isa_pkg::REG_ADDR_W-1:0]      wr_addr,
    input  logic [isa_pkg::WORD_W-1:0]          wr_data
);
    import isa_pkg::*;

    logic [NUM_REGS-1:0][WORD_W-1:0] regs;

    always_ff @(posedge clk)
    begin
        if (!reset)
            regs <= '0;
        else if (wr_en)
            regs[wr_addr] <= wr_data;
    end

    // write-through on all four read ports
    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (wr_en && wr_addr == rd_addr[i])
                rd_data[i] = wr_data;
            else
                rd_data[i] = regs[rd_addr[i]];
        end
    end

endmodule

// File: scoreboard.sv
`timescale 1ns/1ps

module scoreboard (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [3:0][isa_pkg::REG_ADDR_W-1:0] query_addr,
    input  logic [1:0][isa_pkg::REG_ADDR_W-1:0] query_dest,
    output logic [3:0]                          query_busy,
    output logic [1:0]                          dest_busy,
    input  logic                                set_a,
    input  logic                                set_b,
    input  logic [isa_pkg::REG_ADDR_W-1:0]      set_dest_a,
    input  logic [isa_pkg::REG_ADDR_W-1:0]      set_dest_b,
    input  logic                                clear,
    input  logic [isa_pkg::REG_ADDR_W-1:0]      clear_dest
);
    import isa_pkg::*;

    logic [NUM_REGS-1:0] busy;

    // issue never targets a busy register, so set and clear never meet on one bit
    always_ff @(posedge clk)
    begin
        if (!reset)
            busy <= '0;
        else
        begin
            if (clear)
                busy[clear_dest] <= 1'b0;
            if (set_a)
                busy[set_dest_a] <= 1'b1;
            if (set_b)
                busy[set_dest_b] <= 1'b1;
        end
    end

    always_comb
    begin
        for (int i = 0; i < 4; i++)
            query_busy[i] = busy[query_addr[i]];
        for (int j = 0; j < 2; j++)
            dest_busy[j] = busy[query_dest[j]];
    end

endmodule

// File: issue_queue.sv
`timescale 1ns/1ps

module issue_queue (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  in_valid_a,
    input  logic                                  in_valid_b,
    input  isa_pkg::op_t                          in_op_a,
    input  isa_pkg::op_t                          in_op_b,
    input  logic [isa_pkg::REG_ADDR_W-1:0]        in_dest_a,
    input  logic [isa_pkg::REG_ADDR_W-1:0]        in_dest_b,
    input  logic [isa_pkg::REG_ADDR_W-1:0]        in_srca_a,
    input  logic [isa_pkg::REG_ADDR_W-1:0]        in_srca_b,
    input  logic [isa_pkg::REG_ADDR_W-1:0]        in_srcb_a,
    input  logic [isa_pkg::REG_ADDR_W-1:0]        in_srcb_b,
    input  logic [isa_pkg::IMM_W-1:0]             in_imm_a,
    input  logic [isa_pkg::IMM_W-1:0]             in_imm_b,
    output logic                                  in_ready,
    output logic [3:0][isa_pkg::REG_ADDR_W-1:0]   rd_addr,
    input  logic [3:0]                            src_busy,
    input  logic [1:0]                            dest_busy,
    input  logic [core_pkg::NUM_LANES-1:0]        lane_ready,
    output logic                                  issue_a,
    output logic                                  issue_b,
    output isa_pkg::op_t                          iss_op_a,
    output isa_pkg::op_t                          iss_op_b,
    output logic [isa_pkg::REG_ADDR_W-1:0]        iss_dest_a,
    output logic [isa_pkg::REG_ADDR_W-1:0]        iss_dest_b,
    output logic [isa_pkg::IMM_W-1:0]             iss_imm_a,
    output logic [isa_pkg::IMM_W-1:0]             iss_imm_b
);
    import isa_pkg::*;
    import core_pkg::*;

    logic [QUEUE_DEPTH-1:0] valid;
    op_t                    q_op   [QUEUE_DEPTH];
    logic [REG_ADDR_W-1:0]  q_dest [QUEUE_DEPTH];
    logic [REG_ADDR_W-1:0]  q_srca [QUEUE_DEPTH];
    logic [REG_ADDR_W-1:0]  q_srcb [QUEUE_DEPTH];
    logic [IMM_W-1:0]       q_imm  [QUEUE_DEPTH];

    logic [QUEUE_PTR_W-1:0] head;
    logic [QUEUE_PTR_W-1:0] head_p1;
    logic [QUEUE_PTR_W-1:0] tail;
    logic [QUEUE_PTR_W-1:0] tail_p1;

    logic accept;
    logic a_srcs_free;
    logic b_srcs_free;
    logic b_no_raw;

    assign head_p1 = head + QUEUE_PTR_W'(1);
    assign tail_p1 = tail + QUEUE_PTR_W'(1);

    // entries stay contiguous, so two free slots at the tail means room for a pair
    assign in_ready = !valid[tail] && !valid[tail_p1];
    assign accept   = in_valid_a && in_ready;

    assign iss_op_a   = q_op[head];
    assign iss_op_b   = q_op[head_p1];
    assign iss_dest_a = q_dest[head];
    assign iss_dest_b = q_dest[head_p1];
    assign iss_imm_a  = q_imm[head];
    assign iss_imm_b  = q_imm[head_p1];

    assign rd_addr[0] = q_srca[head];
    assign rd_addr[1] = q_srcb[head];
    assign rd_addr[2] = q_srca[head_p1];
    assign rd_addr[3] = q_srcb[head_p1];

    // srcb is not read by ADDI, so it neither stalls nor pairs against it
    assign a_srcs_free = !src_busy[0] && (!src_busy[1] || iss_op_a == ADDI);
    assign b_srcs_free = !src_busy[2] && (!src_busy[3] || iss_op_b == ADDI);
    assign b_no_raw    = (rd_addr[2] != iss_dest_a)
                      && (rd_addr[3] != iss_dest_a || iss_op_b == ADDI);

    assign issue_a = valid[head] && a_srcs_free && !dest_busy[0] && lane_ready[0];

    assign issue_b = issue_a && valid[head_p1] && b_srcs_free && b_no_raw
                  && !dest_busy[1] && (iss_dest_b != iss_dest_a) && lane_ready[1];

    // payload storage
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            q_op[tail]   <= in_op_a;
            q_dest[tail] <= in_dest_a;
            q_srca[tail] <= in_srca_a;
            q_srcb[tail] <= in_srcb_a;
            q_imm[tail]  <= in_imm_a;
            if (in_valid_b)
            begin
                q_op[tail_p1]   <= in_op_b;
                q_dest[tail_p1] <= in_dest_b;
                q_srca[tail_p1] <= in_srca_b;
                q_srcb[tail_p1] <= in_srcb_b;
                q_imm[tail_p1]  <= in_imm_b;
            end
        end
    end

    // tail slots written here are free, head slots cleared are valid, so no overlap
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            valid <= '0;
            head  <= '0;
            tail  <= '0;
        end
        else
        begin
            if (issue_a)
                valid[head] <= 1'b0;
            if (issue_b)
                valid[head_p1] <= 1'b0;
            if (accept)
            begin
                valid[tail] <= 1'b1;
                if (in_valid_b)
                    valid[tail_p1] <= 1'b1;
            end

            if (issue_b)
                head <= head + QUEUE_PTR_W'(2);
            else if (issue_a)
                head <= head_p1;

            if (accept)
                tail <= in_valid_b ? tail + QUEUE_PTR_W'(2) : tail_p1;
        end
    end

endmodule

// File: core_pkg.sv
package core_pkg;

    // issue queue storage
    localparam int QUEUE_DEPTH = 8;
    localparam int QUEUE_PTR_W = 3;

    // lane 0 takes slot A, lane 1 takes slot B
    localparam int NUM_LANES = 2;

endpackage

// File: isa_pkg.sv
package isa_pkg;

    // register addresses, eight general registers, r0 is not hardwired
    localparam int REG_ADDR_W = 3;
    localparam int NUM_REGS   = 8;

    localparam int WORD_W = 32;

    // immediate is sign-extended to a full word in the lane
    localparam int IMM_W = 16;

    localparam int OP_W = 3;

    // ADDI reads srca and imm, every other op reads srca and srcb
    typedef enum logic [OP_W-1:0] {
        ADD  = 3'd0,
        SUB  = 3'd1,
        AND  = 3'd2,
        OR   = 3'd3,
        XOR  = 3'd4,
        SLT  = 3'd5,
        ADDI = 3'd6
    } op_t;

endpackage
